//--- hw/mips_pkg.sv
// shared types, opcode and control encodings for the single cycle MIPS core and its testbench
`default_nettype none

package mips_pkg;

	// ----------------------------------------
	// basic words
	// ----------------------------------------
	typedef logic [31:0] word_t;     // data or byte address
	typedef logic [4:0]  reg_addr_t; // register index

	localparam int DMEM_WORDS = 64; // data memory depth in words

	// ----------------------------------------
	// instruction encodings
	// ----------------------------------------
	typedef enum logic [5:0] {
		OP_RTYPE = 6'b000000,
		OP_BGEZ  = 6'b000001, // rs against zero
		OP_J     = 6'b000010,
		OP_BEQ   = 6'b000100,
		OP_BNE   = 6'b000101,
		OP_BGT   = 6'b000111, // signed rs > rt
		OP_ADDI  = 6'b001000,
		OP_SLTI  = 6'b001010,
		OP_ORI   = 6'b001101, // zero extended imm
		OP_LUI   = 6'b001111,
		OP_LW    = 6'b100011,
		OP_SW    = 6'b101011
	} opcode_e;

	typedef enum logic [5:0] {
		FN_ADD = 6'b100000,
		FN_SUB = 6'b100010,
		FN_AND = 6'b100100,
		FN_OR  = 6'b100101,
		FN_SLT = 6'b101010
	} funct_e;

	// decoder to execute unit
	typedef enum logic [2:0] {
		ALUOP_SUB   = 3'b001,
		ALUOP_RTYPE = 3'b010, // look at funct
		ALUOP_SLT   = 3'b011,
		ALUOP_LUI   = 3'b100,
		ALUOP_SGE   = 3'b101,
		ALUOP_ADD   = 3'b110,
		ALUOP_OR    = 3'b111
	} alu_op_e;

	typedef enum logic [1:0] {
		BR_EQ  = 2'b00,
		BR_GT  = 2'b01,
		BR_GEZ = 2'b10,
		BR_NE  = 2'b11
	} branch_type_e;

	typedef enum logic [1:0] {
		WB_ALU = 2'b00,
		WB_MEM = 2'b01 // codes 10 and 11 unused
	} mem_to_reg_e;

	// ----------------------------------------
	// control and write-back bundles
	// ----------------------------------------
	typedef struct packed {
		logic         reg_dst;     // rd instead of rt
		logic         alu_src;     // imm as operand b
		logic         reg_write;
		logic         branch;
		branch_type_e branch_type;
		logic         jump;
		logic         mem_read;
		logic         mem_write;
		mem_to_reg_e  mem_to_reg;
		logic         read_rt;     // 0 forces operand b to zero
		logic         imm_zext;
		alu_op_e      alu_op;
		logic         illegal;     // unknown opcode
	} ctrl_t;

	typedef struct packed {
		logic      en;
		reg_addr_t addr;
		word_t     data;
	} wb_t;

endpackage

`default_nettype wire

//--- hw/decoder.sv
// main control decoder that turns the opcode field into the control bundle for one instruction
`default_nettype none
`timescale 1ns/100ps

module decoder import mips_pkg::*; (
	input  opcode_e opcode_i,
	input  logic    rst_i,
	output ctrl_t   ctrl_o
);

	always_comb begin
		// defaults are a no-op
		ctrl_o.reg_dst     = 1'b0;
		ctrl_o.alu_src     = 1'b0;
		ctrl_o.reg_write   = 1'b0;
		ctrl_o.branch      = 1'b0;
		ctrl_o.branch_type = BR_EQ;
		ctrl_o.jump        = 1'b0;
		ctrl_o.mem_read    = 1'b0;
		ctrl_o.mem_write   = 1'b0;
		ctrl_o.mem_to_reg  = WB_ALU;
		ctrl_o.read_rt     = 1'b1;
		ctrl_o.imm_zext    = 1'b0;
		ctrl_o.alu_op      = ALUOP_ADD;
		ctrl_o.illegal     = 1'b0;

		// ----------------------------------------
		// per opcode overrides
		// ----------------------------------------
		case (opcode_i)
			OP_RTYPE: begin
				ctrl_o.reg_dst   = 1'b1; // write rd
				ctrl_o.reg_write = 1'b1;
				ctrl_o.alu_op    = ALUOP_RTYPE;
			end
			OP_ADDI, OP_SLTI, OP_LUI, OP_ORI: begin
				ctrl_o.alu_src   = 1'b1;
				ctrl_o.reg_write = 1'b1;
				case (opcode_i)
					OP_SLTI: ctrl_o.alu_op = ALUOP_SLT;
					OP_LUI:  ctrl_o.alu_op = ALUOP_LUI;
					OP_ORI:  ctrl_o.alu_op = ALUOP_OR;
					default: ctrl_o.alu_op = ALUOP_ADD; // addi
				endcase
				ctrl_o.imm_zext = (opcode_i == OP_ORI); // only ori zero extends
			end
			OP_LW: begin
				ctrl_o.alu_src    = 1'b1;
				ctrl_o.reg_write  = 1'b1;
				ctrl_o.mem_read   = 1'b1;
				ctrl_o.mem_to_reg = WB_MEM;
			end
			OP_SW: begin
				ctrl_o.alu_src   = 1'b1;
				ctrl_o.mem_write = 1'b1; // address is rs + imm
			end
			OP_BEQ, OP_BNE, OP_BGT: begin
				ctrl_o.branch = 1'b1;
				ctrl_o.alu_op = ALUOP_SUB;
				case (opcode_i)
					OP_BNE:  ctrl_o.branch_type = BR_NE;
					OP_BGT:  ctrl_o.branch_type = BR_GT;
					default: ctrl_o.branch_type = BR_EQ;
				endcase
			end
			OP_BGEZ: begin
				ctrl_o.branch      = 1'b1;
				ctrl_o.branch_type = BR_GEZ;
				ctrl_o.read_rt     = 1'b0; // compare rs with zero
				ctrl_o.alu_op      = ALUOP_SGE;
			end
			OP_J: begin
				ctrl_o.jump   = 1'b1;
				ctrl_o.alu_op = ALUOP_RTYPE; // alu result unused
			end
			default: ctrl_o.illegal = 1'b1; // behaves as a no-op
		endcase

		// nothing commits while in reset
		if (rst_i) begin
			ctrl_o.reg_write = 1'b0;
			ctrl_o.mem_write = 1'b0;
			ctrl_o.mem_read  = 1'b0;
			ctrl_o.branch    = 1'b0;
			ctrl_o.jump      = 1'b0;
			ctrl_o.illegal   = 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- hw/reg_file.sv
// 32 entry register file with two combinational reads and one write per clock for the core
`default_nettype none
`timescale 1ns/100ps

module reg_file import mips_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_i,
	input  reg_addr_t rs_i,
	input  reg_addr_t rt_i,
	input  logic      read_rt_i, // low for bgez
	input  wb_t       wb_i,
	output word_t     rs_val_o,
	output word_t     rt_val_o
);

	word_t regs [32];

	// ----------------------------------------
	// write port
	// ----------------------------------------
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_i.en && (wb_i.addr != '0)) begin // $0 stays zero
			regs[wb_i.addr] <= wb_i.data;
		end
	end

	// ----------------------------------------
	// read ports, no bypass
	// ----------------------------------------
	always_comb begin
		rs_val_o = regs[rs_i];
		if (rs_i == '0) begin
			rs_val_o = '0;
		end

		rt_val_o = regs[rt_i];
		if (!read_rt_i || (rt_i == '0)) begin
			rt_val_o = '0; // operand b is zero
		end
	end

endmodule

`default_nettype wire

//--- hw/exec_unit.sv
// execute stage of the core with ALU control, immediate extension, ALU, branch decision and write-back
`default_nettype none
`timescale 1ns/100ps

module exec_unit import mips_pkg::*; (
	input  ctrl_t ctrl_i,
	input  word_t instr_i,
	input  word_t pc_i,
	input  word_t rs_val_i,
	input  word_t rt_val_i,
	input  word_t mem_rdata_i,
	output word_t mem_addr_o,
	output word_t mem_wdata_o,
	output logic  br_taken_o,
	output word_t br_target_o,
	output word_t jmp_target_o,
	output wb_t   wb_o
);

	typedef enum logic [2:0] {
		ALU_NONE, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_LUI, ALU_SGE
	} alu_fn_e;

	funct_e      funct;
	reg_addr_t   rt_idx;
	reg_addr_t   rd_idx;
	logic [15:0] imm;
	word_t       imm_sext;
	word_t       imm_ext;
	word_t       op_b;
	word_t       pc_plus4;
	alu_fn_e     alu_fn;
	logic        funct_bad;
	word_t       alu_res;
	logic        alu_zero;
	logic        lt_signed;
	logic        cond;

	// instruction fields
	assign funct  = funct_e'(instr_i[5:0]);
	assign rt_idx = instr_i[20:16];
	assign rd_idx = instr_i[15:11];
	assign imm    = instr_i[15:0];

	assign imm_sext = {{16{imm[15]}}, imm};
	assign imm_ext  = ctrl_i.imm_zext ? {16'b0, imm} : imm_sext; // ori
	assign op_b     = ctrl_i.alu_src ? imm_ext : rt_val_i;

	// ----------------------------------------
	// alu control
	// ----------------------------------------
	always_comb begin
		funct_bad = 1'b0;
		case (ctrl_i.alu_op)
			ALUOP_RTYPE: begin
				case (funct)
					FN_ADD:  alu_fn = ALU_ADD;
					FN_SUB:  alu_fn = ALU_SUB;
					FN_AND:  alu_fn = ALU_AND;
					FN_OR:   alu_fn = ALU_OR;
					FN_SLT:  alu_fn = ALU_SLT;
					default: begin
						alu_fn    = ALU_NONE;
						funct_bad = 1'b1; // sll and friends
					end
				endcase
			end
			ALUOP_ADD: alu_fn = ALU_ADD; // addi, lw, sw
			ALUOP_SUB: alu_fn = ALU_SUB; // beq, bne, bgt
			ALUOP_SLT: alu_fn = ALU_SLT;
			ALUOP_LUI: alu_fn = ALU_LUI;
			ALUOP_SGE: alu_fn = ALU_SGE; // bgez
			ALUOP_OR:  alu_fn = ALU_OR;
			default:   alu_fn = ALU_NONE;
		endcase

		// the instruction source must not issue these
		assert final (!(ctrl_i.reg_write && funct_bad))
			else $error("unknown funct with reg_write");
	end

	// ----------------------------------------
	// alu
	// ----------------------------------------
	assign lt_signed = ($signed(rs_val_i) < $signed(op_b));

	always_comb begin
		case (alu_fn)
			ALU_ADD: alu_res = rs_val_i + op_b;
			ALU_SUB: alu_res = rs_val_i - op_b;
			ALU_AND: alu_res = rs_val_i & op_b;
			ALU_OR:  alu_res = rs_val_i | op_b;
			ALU_SLT: alu_res = {31'b0, lt_signed};
			ALU_LUI: alu_res = {imm_ext[15:0], 16'b0};
			ALU_SGE: alu_res = {31'b0, ~lt_signed}; // op_b is zero here
			default: alu_res = '0;
		endcase
	end

	assign alu_zero = (alu_res == '0);

	// branch condition
	always_comb begin
		case (ctrl_i.branch_type)
			BR_EQ:   cond = alu_zero;
			BR_NE:   cond = ~alu_zero;
			BR_GT:   cond = ~lt_signed & ~alu_zero; // signed rs > rt
			BR_GEZ:  cond = alu_res[0];
			default: cond = 1'b0;
		endcase
	end

	assign br_taken_o = ctrl_i.branch & cond;

	// targets
	assign pc_plus4     = pc_i + 32'd4;
	assign br_target_o  = pc_plus4 + {imm_sext[29:0], 2'b00};
	assign jmp_target_o = {pc_plus4[31:28], instr_i[25:0], 2'b00};

	// memory side
	assign mem_addr_o  = alu_res;
	assign mem_wdata_o = rt_val_i;

	// ----------------------------------------
	// write-back
	// ----------------------------------------
	assign wb_o.en   = ctrl_i.reg_write & ~ctrl_i.illegal & ~funct_bad;
	assign wb_o.addr = ctrl_i.reg_dst ? rd_idx : rt_idx;
	assign wb_o.data = (ctrl_i.mem_to_reg == WB_MEM) ? mem_rdata_i : alu_res;

endmodule

`default_nettype wire

//--- hw/data_mem.sv
// word addressed data memory for lw and sw with combinational read and clocked write
`default_nettype none
`timescale 1ns/100ps

module data_mem import mips_pkg::*; (
	input  logic  clk_i,
	input  logic  mem_read_i,
	input  logic  mem_write_i,
	input  word_t addr_i,
	input  word_t wdata_i,
	output word_t rdata_o
);

	word_t      mem [DMEM_WORDS];
	logic [5:0] idx; // word index

	assign idx = addr_i[7:2];

	always_ff @(posedge clk_i) begin
		if (mem_write_i) begin
			mem[idx] <= wdata_i;
		end
	end

	assign rdata_o = mem_read_i ? mem[idx] : '0; // quiet when idle

	// one access kind per instruction
	assert property (@(posedge clk_i) !(mem_read_i && mem_write_i))
		else $error("data memory read and write together");

	assert property (@(posedge clk_i) (mem_read_i || mem_write_i) |-> (addr_i[1:0] == 2'b00))
		else $error("unaligned data memory access");

endmodule

`default_nettype wire

//--- hw/pc_unit.sv
// program counter of the core that picks the next fetch address each clock
`default_nettype none
`timescale 1ns/100ps

module pc_unit import mips_pkg::*; (
	input  logic  clk_i,
	input  logic  rst_i,
	input  logic  br_taken_i,
	input  logic  jump_i,
	input  word_t br_target_i,
	input  word_t jmp_target_i,
	output word_t pc_o
);

	word_t pc_q;
	word_t pc_next;

	// jump wins over branch, then sequential
	always_comb begin
		if (jump_i) begin
			pc_next = jmp_target_i;
		end else if (br_taken_i) begin
			pc_next = br_target_i;
		end else begin
			pc_next = pc_q + 32'd4;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			pc_q <= '0;
		end else begin
			pc_q <= pc_next;
		end
	end

	assign pc_o = pc_q;

	// ----------------------------------------
	// checks
	// ----------------------------------------
	assert property (@(posedge clk_i) disable iff (rst_i) pc_q[1:0] == 2'b00)
		else $error("pc not word aligned");

endmodule

`default_nettype wire

//--- hw/mips_core.sv
// top level of the single cycle MIPS core that fetches one instruction per clock from the testbench
`default_nettype none
`timescale 1ns/100ps

module mips_core import mips_pkg::*; (
	input  logic  clk_i,
	input  logic  rst_i,
	input  word_t instr_i,   // served for pc_o in the same cycle
	output word_t pc_o,
	output wb_t   wb_o,      // register write of this cycle
	output logic  illegal_o
);

	opcode_e   opcode;
	reg_addr_t rs_idx;
	reg_addr_t rt_idx;
	ctrl_t     ctrl;
	word_t     rs_val;
	word_t     rt_val;
	word_t     mem_addr;
	word_t     mem_wdata;
	word_t     mem_rdata;
	logic      br_taken;
	word_t     br_target;
	word_t     jmp_target;
	wb_t       wb;
	word_t     pc;

	// ----------------------------------------
	// field split
	// ----------------------------------------
	assign opcode = opcode_e'(instr_i[31:26]);
	assign rs_idx = instr_i[25:21];
	assign rt_idx = instr_i[20:16];

	decoder decoder_i (
		.opcode_i (opcode),
		.rst_i    (rst_i),
		.ctrl_o   (ctrl)
	);

	reg_file reg_file_i (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.rs_i      (rs_idx),
		.rt_i      (rt_idx),
		.read_rt_i (ctrl.read_rt),
		.wb_i      (wb),
		.rs_val_o  (rs_val),
		.rt_val_o  (rt_val)
	);

	exec_unit exec_unit_i (
		.ctrl_i       (ctrl),
		.instr_i      (instr_i),
		.pc_i         (pc),
		.rs_val_i     (rs_val),
		.rt_val_i     (rt_val),
		.mem_rdata_i  (mem_rdata),
		.mem_addr_o   (mem_addr),
		.mem_wdata_o  (mem_wdata),
		.br_taken_o   (br_taken),
		.br_target_o  (br_target),
		.jmp_target_o (jmp_target),
		.wb_o         (wb)
	);

	data_mem data_mem_i (
		.clk_i       (clk_i),
		.mem_read_i  (ctrl.mem_read),
		.mem_write_i (ctrl.mem_write),
		.addr_i      (mem_addr),
		.wdata_i     (mem_wdata),
		.rdata_o     (mem_rdata)
	);

	pc_unit pc_unit_i (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.br_taken_i   (br_taken),
		.jump_i       (ctrl.jump),
		.br_target_i  (br_target),
		.jmp_target_i (jmp_target),
		.pc_o         (pc)
	);

	assign pc_o      = pc;
	assign wb_o      = wb;
	assign illegal_o = ctrl.illegal; // already low in reset

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
// clock and reset source for the core testbench; 100 ns clock, 16 reset cycles on each request
`default_nettype none
`timescale 1ns/100ps

module tb_clock (
	input  logic rst_req_i, // sampled on the rising edge
	output logic clk_o,
	output logic rst_o
);

	localparam int HALF_NS      = 50;
	localparam int RESET_CYCLES = 16;

	int   cnt;
	logic req;

	initial begin
		clk_o = 1'b0;
		rst_o = 1'b1; // power-on reset
		cnt   = RESET_CYCLES;
	end

	always #HALF_NS clk_o = ~clk_o;

	// reset moves 1 ns after the edge like all other stimulus
	always @(posedge clk_o) begin
		req = rst_req_i;
		#1;
		if (req) begin
			cnt = RESET_CYCLES;
		end else if (cnt > 0) begin
			cnt = cnt - 1;
		end
		rst_o = (cnt > 0);
	end

endmodule

`default_nettype wire

//--- sim/tb_mips_core.sv
// directed testbench for the single cycle core; serves instructions and checks against an ISA model
`default_nettype none
`timescale 1ns/100ps

module tb_mips_core import mips_pkg::*; ();

	localparam int    CLK_NS        = 100;
	localparam int    RESET_CYCLES  = 16;
	localparam int    NUM_TESTS     = 6;
	localparam int    STEPS_RESET   = 4;
	localparam int    STEPS_ALU     = 21;
	localparam int    STEPS_MEM     = 18;
	localparam int    STEPS_BRANCH  = 27;
	localparam int    STEPS_JUMP    = 4;
	localparam int    STEPS_ILLEGAL = 8;
	localparam int    TOTAL_STEPS   = STEPS_RESET + STEPS_ALU + STEPS_MEM + STEPS_BRANCH
		+ STEPS_JUMP + STEPS_ILLEGAL;
	localparam int    WATCHDOG_NS   = (TOTAL_STEPS * 2 + NUM_TESTS * (RESET_CYCLES + 4)) * CLK_NS;
	localparam word_t NOP           = 32'h0000_0020; // add $0,$0,$0

	logic  clk;
	logic  rst;
	logic  rst_req;
	word_t instr;
	word_t pc;
	wb_t   wb;
	logic  illegal;

	word_t rom [256];          // instruction ROM indexed by pc bits 9:2
	word_t prog [$];           // program staged by a test
	word_t m_regs [32];        // model register file
	word_t m_mem [DMEM_WORDS]; // model data memory kept across resets
	word_t m_pc;
	word_t rng;
	int    test_errors;
	int    pass_count;
	int    fail_count;

	tb_clock clock_i (
		.rst_req_i (rst_req),
		.clk_o     (clk),
		.rst_o     (rst)
	);

	mips_core mips_core_i (
		.clk_i     (clk),
		.rst_i     (rst),
		.instr_i   (instr),
		.pc_o      (pc),
		.wb_o      (wb),
		.illegal_o (illegal)
	);

	// fetch port answered 1 ns after the edge
	always @(posedge clk) begin
		#1;
		instr = rom[pc[9:2]];
	end

	function automatic word_t xorshift32();
		word_t x;
		x = rng;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng = x;
		return x;
	endfunction

	// ----------------------------------------
	// instruction encoding
	// ----------------------------------------
	function automatic word_t rtype_word(funct_e fn, reg_addr_t rd, reg_addr_t rs, reg_addr_t rt);
		return {6'b000000, rs, rt, rd, 5'b00000, fn};
	endfunction

	function automatic word_t itype_word(logic [5:0] op, reg_addr_t rt, reg_addr_t rs,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic load_word(input reg_addr_t r, input word_t v);
		prog.push_back(itype_word(OP_LUI, r, 5'd0, v[31:16]));
		prog.push_back(itype_word(OP_ORI, r, r, v[15:0])); // low half zero extended
	endtask

	function automatic wb_t make_wb(reg_addr_t dst, word_t data);
		wb_t w;
		w.en   = 1'b1;
		w.addr = dst;
		w.data = data;
		return w;
	endfunction

	// ----------------------------------------
	// reference model, one instruction
	// ----------------------------------------
	task automatic model_step(input word_t ins, output wb_t exp_wb, output logic exp_ill);
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		word_t     a;
		word_t     b;
		word_t     sx;
		word_t     zx;
		word_t     pc4;
		word_t     nxt;
		word_t     addr;
		rs   = ins[25:21];
		rt   = ins[20:16];
		rd   = ins[15:11];
		a    = m_regs[rs];
		b    = m_regs[rt];
		sx   = {{16{ins[15]}}, ins[15:0]};
		zx   = {16'h0000, ins[15:0]};
		pc4  = m_pc + 32'd4;
		nxt  = pc4;
		addr = a + sx; // lw/sw effective address
		exp_wb  = '0;
		exp_ill = 1'b0;
		case (opcode_e'(ins[31:26]))
			OP_RTYPE: begin
				case (funct_e'(ins[5:0]))
					FN_ADD:  exp_wb = make_wb(rd, a + b);
					FN_SUB:  exp_wb = make_wb(rd, a - b);
					FN_AND:  exp_wb = make_wb(rd, a & b);
					FN_OR:   exp_wb = make_wb(rd, a | b);
					FN_SLT:  exp_wb = make_wb(rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
					default: exp_wb.en = 1'b0;
				endcase
			end
			OP_ADDI: exp_wb = make_wb(rt, a + sx);
			OP_SLTI: exp_wb = make_wb(rt, ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0);
			OP_ORI:  exp_wb = make_wb(rt, a | zx);
			OP_LUI:  exp_wb = make_wb(rt, {ins[15:0], 16'h0000});
			OP_LW:   exp_wb = make_wb(rt, m_mem[addr[7:2]]);
			OP_SW:   m_mem[addr[7:2]] = b;
			OP_BEQ:  if (a == b) nxt = pc4 + {sx[29:0], 2'b00};
			OP_BNE:  if (a != b) nxt = pc4 + {sx[29:0], 2'b00};
			OP_BGT:  if ($signed(a) > $signed(b)) nxt = pc4 + {sx[29:0], 2'b00};
			OP_BGEZ: if (!a[31]) nxt = pc4 + {sx[29:0], 2'b00}; // rt field ignored
			OP_J:    nxt = {pc4[31:28], ins[25:0], 2'b00};
			default: exp_ill = 1'b1; // no-op apart from the flag
		endcase
		if (exp_wb.en && (exp_wb.addr != 5'd0)) begin
			m_regs[exp_wb.addr] = exp_wb.data;
		end
		m_pc = nxt;
	endtask

	// ----------------------------------------
	// compare tasks
	// ----------------------------------------
	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
			test_errors++;
		end
	endtask

	task automatic check_wb(input wb_t got, input wb_t exp);
		if (got.en !== exp.en) begin
			$display("ERROR wb_o.en got %h expected %h at %0t", got.en, exp.en, $time);
			test_errors++;
		end else if (exp.en && ((got.addr !== exp.addr) || (got.data !== exp.data))) begin
			$display("ERROR wb_o got %h:%h expected %h:%h at %0t",
				got.addr, got.data, exp.addr, exp.data, $time);
			test_errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
			test_errors++;
		end
	endtask

	// sampled at the falling edge between commits
	task automatic step_and_check();
		word_t ins;
		wb_t   exp_wb;
		logic  exp_ill;
		ins = rom[m_pc[9:2]];
		check_word("pc_o", pc, m_pc);
		model_step(ins, exp_wb, exp_ill);
		check_wb(wb, exp_wb);
		check_flag("illegal_o", illegal, exp_ill);
	endtask

	// reset the core, load the staged program, then step and compare
	task automatic run_program(input int steps, input bit check_reset);
		rst_req = 1'b1;
		@(posedge clk);
		#1;
		rst_req = 1'b0;
		wait (rst);
		foreach (rom[i]) rom[i] = NOP;
		foreach (prog[i]) rom[i] = prog[i];
		foreach (m_regs[i]) m_regs[i] = '0;
		m_pc = '0;
		@(posedge clk); // first edge with reset high
		do begin
			@(negedge clk);
			if (check_reset && rst) begin
				check_word("pc_o", pc, 32'd0);
				check_flag("wb_o.en", wb.en, 1'b0);
				check_flag("illegal_o", illegal, 1'b0);
			end
			@(posedge clk);
			#2;
		end while (rst);
		repeat (steps) begin
			@(negedge clk);
			step_and_check();
		end
	endtask

	task automatic report_test(input string name);
		if (test_errors == 0) begin
			$display("test %s: pass", name);
			pass_count++;
		end else begin
			$display("test %s: fail with %0d errors", name, test_errors);
			fail_count++;
		end
		test_errors = 0;
	endtask

	// ----------------------------------------
	// directed tests
	// ----------------------------------------
	task automatic run_reset_check();
		prog.delete();
		prog.push_back(itype_word(OP_ADDI, 5'd1, 5'd0, 16'h1234)); // a write that reset must mask
		prog.push_back(itype_word(OP_BNE, 5'd0, 5'd0, 16'h0004)); // never taken and no write
		prog.push_back(rtype_word(FN_ADD, 5'd2, 5'd1, 5'd1));
		run_program(STEPS_RESET, 1'b1);
		report_test("reset");
	endtask

	task automatic exercise_alu();
		word_t a;
		word_t b;
		word_t c;
		word_t d;
		prog.delete();
		a = xorshift32() | 32'h8000_0000; // negative for the signed compares
		b = xorshift32() & 32'h7fff_ffff;
		c = xorshift32();
		d = xorshift32();
		load_word(5'd1, a);
		load_word(5'd2, b);
		load_word(5'd3, c);
		load_word(5'd4, d);
		prog.push_back(rtype_word(FN_ADD, 5'd5, 5'd1, 5'd2));
		prog.push_back(rtype_word(FN_SUB, 5'd6, 5'd1, 5'd2));
		prog.push_back(rtype_word(FN_AND, 5'd7, 5'd3, 5'd4));
		prog.push_back(rtype_word(FN_OR, 5'd8, 5'd3, 5'd4));
		prog.push_back(rtype_word(FN_SLT, 5'd9, 5'd1, 5'd2));
		prog.push_back(rtype_word(FN_SLT, 5'd10, 5'd2, 5'd1));
		prog.push_back(itype_word(OP_ADDI, 5'd11, 5'd3, d[15:0]));
		prog.push_back(itype_word(OP_SLTI, 5'd12, 5'd1, d[31:16]));
		prog.push_back(itype_word(OP_ORI, 5'd13, 5'd0, {1'b1, c[14:0]})); // top bit set
		prog.push_back(rtype_word(FN_ADD, 5'd0, 5'd1, 5'd2)); // $0 stays zero
		prog.push_back(rtype_word(FN_ADD, 5'd14, 5'd0, 5'd0));
		run_program(STEPS_ALU, 1'b0);
		report_test("alu");
	endtask

	task automatic store_and_load();
		word_t       r;
		word_t       v [4];
		logic [15:0] off [4];
		reg_addr_t   base;
		prog.delete();
		foreach (v[i]) begin
			v[i]   = xorshift32();
			r      = xorshift32();
			off[i] = {8'h00, r[7:2], 2'b00}; // random word offset
			load_word(reg_addr_t'(i + 1), v[i]);
		end
		prog.push_back(itype_word(OP_ADDI, 5'd9, 5'd0, 16'h0040)); // second base
		foreach (v[i]) begin
			base = (i < 2) ? 5'd0 : 5'd9;
			prog.push_back(itype_word(OP_SW, reg_addr_t'(i + 1), base, off[i]));
		end
		foreach (v[i]) begin
			base = (i < 2) ? 5'd0 : 5'd9;
			prog.push_back(itype_word(OP_LW, reg_addr_t'(i + 5), base, off[i]));
		end
		run_program(STEPS_MEM, 1'b0);
		report_test("memory");
	endtask

	// branch skips one marker when taken
	task automatic branch_pair(input logic [5:0] op, input reg_addr_t rs, input reg_addr_t rt);
		prog.push_back(itype_word(op, rt, rs, 16'h0001));
		prog.push_back(itype_word(OP_ADDI, 5'd20, 5'd20, 16'h0001));
	endtask

	task automatic take_branches();
		word_t p;
		word_t n;
		word_t q;
		prog.delete();
		p = xorshift32() & 32'h7fff_ffff;
		n = xorshift32() | 32'h8000_0000;
		q = xorshift32() & 32'h7fff_ffff;
		load_word(5'd1, p);
		prog.push_back(rtype_word(FN_ADD, 5'd2, 5'd1, 5'd0)); // copy of r1
		load_word(5'd3, n);
		load_word(5'd4, q);
		branch_pair(OP_BEQ, 5'd1, 5'd2);  // taken
		branch_pair(OP_BEQ, 5'd1, 5'd3);
		branch_pair(OP_BNE, 5'd1, 5'd3);  // taken
		branch_pair(OP_BNE, 5'd1, 5'd2);
		branch_pair(OP_BGT, 5'd4, 5'd3);  // taken
		branch_pair(OP_BGT, 5'd3, 5'd4);
		branch_pair(OP_BGEZ, 5'd4, 5'd0); // taken
		branch_pair(OP_BGEZ, 5'd3, 5'd3); // negative rs and rt not read
		branch_pair(OP_BGEZ, 5'd0, 5'd4); // zero counts as taken whatever rt holds
		run_program(STEPS_BRANCH, 1'b0);
		report_test("branch");
	endtask

	task automatic jump_over();
		word_t v;
		prog.delete();
		v = xorshift32();
		prog.push_back(itype_word(OP_ADDI, 5'd5, 5'd0, v[15:0]));
		prog.push_back({OP_J, 26'd8}); // to byte address 32
		prog.push_back(itype_word(OP_ADDI, 5'd5, 5'd0, 16'h0063)); // must be skipped
		while (prog.size() < 8) prog.push_back(NOP);
		prog.push_back(rtype_word(FN_ADD, 5'd7, 5'd5, 5'd0)); // shows r5 untouched
		run_program(STEPS_JUMP, 1'b0);
		report_test("jump");
	endtask

	task automatic reject_illegal();
		word_t v;
		prog.delete();
		v = xorshift32();
		prog.push_back(itype_word(6'b010000, 5'd3, 5'd0, 16'h0008)); // flag masked in reset
		load_word(5'd1, v);
		prog.push_back(itype_word(OP_SW, 5'd1, 5'd0, 16'h0008));
		prog.push_back(itype_word(6'b111111, 5'd2, 5'd0, 16'h0008)); // looks like a store
		prog.push_back(itype_word(OP_LW, 5'd3, 5'd0, 16'h0008));
		prog.push_back(rtype_word(FN_ADD, 5'd4, 5'd3, 5'd0));
		run_program(STEPS_ILLEGAL, 1'b1);
		report_test("illegal");
	endtask

	// ----------------------------------------
	// main sequence and watchdog
	// ----------------------------------------
	initial begin
		rst_req     = 1'b0;
		instr       = NOP;
		rng         = 32'd14;
		test_errors = 0;
		pass_count  = 0;
		fail_count  = 0;
		m_pc        = '0;
		foreach (rom[i]) rom[i] = NOP;
		foreach (m_regs[i]) m_regs[i] = '0;
		foreach (m_mem[i]) m_mem[i] = '0;
		@(posedge clk);
		#1;
		run_reset_check();
		exercise_alu();
		store_and_load();
		take_branches();
		jump_over();
		reject_illegal();
		$display("tests passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished");
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
hw/mips_pkg.sv
hw/decoder.sv
hw/reg_file.sv
hw/exec_unit.sv
hw/data_mem.sv
hw/pc_unit.sv
hw/mips_core.sv
sim/tb_clock.sv
sim/tb_mips_core.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f build.f --top-module tb_mips_core -Mdir obj_dir
./obj_dir/Vtb_mips_core > sim.log
cat sim.log
if grep -qx "Everything OK" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
